// File: verilog.f
hdl/vdp_pkg.sv
hdl/vdp_cmd_fifo.sv
hdl/vdp_csr_file.sv
hdl/vdp_fetch_ctrl.sv
hdl/vdp_dot_unit.sv
hdl/vdp_top.sv
tb/vdp_clk_gen.sv
tb/vdp_tb_sva.sv
tb/vdp_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f verilog.f --top-module vdp_tb --Mdir obj_dir -o vdp_sim
	./obj_dir/vdp_sim > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TESTS PASSED" sim.log || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: tb/vdp_tb.sv
`timescale 1ns/1ps

module vdp_tb;

  import vdp_pkg::*;

  localparam int TIMEOUT_CYCLES = 4000;
  localparam int MEM_WORDS      = 2048;

  logic                 clk;
  logic                 reset;
  logic                 cmd_v;
  logic                 cmd_we;
  logic [CSR_IDX_W-1:0] cmd_addr;
  logic [DATA_W-1:0]    cmd_data;
  logic                 cmd_ready;
  logic                 resp_v;
  logic                 resp_we;
  logic [CSR_IDX_W-1:0] resp_addr;
  logic [DATA_W-1:0]    resp_data;
  logic                 resp_ready;
  logic                 req_v;
  logic                 req_we;
  logic [ADDR_W-1:0]    req_addr;
  logic [DATA_W-1:0]    req_data;
  logic                 req_ready;
  logic                 mem_resp_v;
  logic [DATA_W-1:0]    mem_resp_data;

  logic [DATA_W-1:0]    mem_q [MEM_WORDS];
  logic [ADDR_W-1:0]    log_addr_q [$];
  logic                 log_we_q [$];
  logic [DATA_W-1:0]    log_data_q [$];
  integer               seed;
  int                   cycle_cnt;
  int                   n_checks;
  int                   n_errors;

  vdp_clk_gen #(.PERIOD_NS(4)) u_clk (.clk_o(clk));

  vdp_top #(.VEC_LEN(VEC_LEN_MAX)) uut (
    .clk_i           (clk),
    .reset_i         (reset),
    .io_cmd_v_i      (cmd_v),
    .io_cmd_we_i     (cmd_we),
    .io_cmd_addr_i   (cmd_addr),
    .io_cmd_data_i   (cmd_data),
    .io_cmd_ready_o  (cmd_ready),
    .io_resp_v_o     (resp_v),
    .io_resp_we_o    (resp_we),
    .io_resp_addr_o  (resp_addr),
    .io_resp_data_o  (resp_data),
    .io_resp_ready_i (resp_ready),
    .mem_req_v_o     (req_v),
    .mem_req_we_o    (req_we),
    .mem_req_addr_o  (req_addr),
    .mem_req_data_o  (req_data),
    .mem_req_ready_i (req_ready),
    .mem_resp_v_i    (mem_resp_v),
    .mem_resp_data_i (mem_resp_data)
  );

  bind vdp_top vdp_tb_sva u_sva (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .start_i         (start),
    .mem_req_v_i     (mem_req_v_o),
    .mem_req_we_i    (mem_req_we_o),
    .mem_req_addr_i  (mem_req_addr_o),
    .mem_req_data_i  (mem_req_data_o),
    .mem_req_ready_i (mem_req_ready_i),
    .io_resp_v_i     (io_resp_v_o),
    .io_resp_we_i    (io_resp_we_o),
    .io_resp_addr_i  (io_resp_addr_o),
    .io_resp_data_i  (io_resp_data_o),
    .io_resp_ready_i (io_resp_ready_i)
  );

  function automatic int word_index(input logic [ADDR_W-1:0] addr);
    return int'(addr[13:3]);
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Memory model with one request in flight, random ready and 0 to 3 cycles of latency
  initial begin
    logic [31:0]       rnd;
    logic              pend;
    logic              pend_we;
    logic [ADDR_W-1:0] pend_addr;
    logic [DATA_W-1:0] pend_data;
    int                delay;
    seed          = 32'h933d;
    req_ready     = 1'b0;
    mem_resp_v    = 1'b0;
    mem_resp_data = '0;
    pend          = 1'b0;
    pend_we       = 1'b0;
    pend_addr     = '0;
    pend_data     = '0;
    delay         = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_q[i] = {32'($random(seed)), 32'($random(seed)) ^ 32'(i)};
    end
    forever begin
      @(negedge clk);
      mem_resp_v = 1'b0;
      rnd        = $random(seed);
      req_ready  = rnd[0];
      if (pend) begin
        if (delay == 0) begin
          mem_resp_v = 1'b1;
          if (pend_we) begin
            mem_q[word_index(pend_addr)] = pend_data;
            mem_resp_data = '0;
          end else begin
            mem_resp_data = mem_q[word_index(pend_addr)];
          end
          pend = 1'b0;
        end else begin
          delay--;
        end
      end else if (req_v === 1'b1 && req_ready) begin
        // Transfers on the coming rising edge
        pend      = 1'b1;
        pend_we   = req_we;
        pend_addr = req_addr;
        pend_data = req_data;
        delay     = int'(rnd[2:1]);
        log_addr_q.push_back(req_addr);
        log_we_q.push_back(req_we);
        log_data_q.push_back(req_data);
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  task automatic send_cmd(input logic we, input logic [CSR_IDX_W-1:0] idx,
                          input logic [63:0] data);
    @(negedge clk);
    cmd_v    = 1'b1;
    cmd_we   = we;
    cmd_addr = idx;
    cmd_data = data;
    while (!cmd_ready) begin
      @(negedge clk);
    end
    @(negedge clk);
    cmd_v = 1'b0;
  endtask

  task automatic recv_resp(output logic we, output logic [CSR_IDX_W-1:0] idx,
                           output logic [63:0] data);
    @(negedge clk);
    while (!resp_v) begin
      @(negedge clk);
    end
    we         = resp_we;
    idx        = resp_addr;
    data       = resp_data;
    resp_ready = 1'b1;
    @(negedge clk);
    resp_ready = 1'b0;
  endtask

  task automatic csr_write(input logic [CSR_IDX_W-1:0] idx, input logic [63:0] val);
    logic                 we;
    logic [CSR_IDX_W-1:0] addr;
    logic [63:0]          data;
    send_cmd(1'b1, idx, val);
    recv_resp(we, addr, data);
    check_value("write response flag", 64'(we), 64'd1);
    check_value("write response index", 64'(addr), 64'(idx));
    check_value("write response data", data, 64'd0);
  endtask

  task automatic csr_read(input logic [CSR_IDX_W-1:0] idx, output logic [63:0] val);
    logic                 we;
    logic [CSR_IDX_W-1:0] addr;
    send_cmd(1'b0, idx, 64'd0);
    recv_resp(we, addr, val);
    check_value("read response flag", 64'(we), 64'd0);
    check_value("read response index", 64'(addr), 64'(idx));
  endtask

  task automatic write_readback(input logic [CSR_IDX_W-1:0] idx, input logic [63:0] val);
    logic [63:0] rd;
    csr_write(idx, val);
    csr_read(idx, rd);
    check_value($sformatf("CSR %0d readback", idx), rd, val);
  endtask

  task automatic test_reset_values();
    logic [63:0] rd;
    @(negedge clk);
    check_value("response valid after reset", 64'(resp_v), 64'd0);
    check_value("memory request after reset", 64'(req_v), 64'd0);
    for (int i = 0; i < 6; i++) begin
      csr_read(CSR_IDX_W'(i), rd);
      check_value($sformatf("CSR %0d after reset", i), rd,
                  (i == int'(CSR_STATUS)) ? 64'd1 : 64'd0);
    end
  endtask

  task automatic test_csr_round_trip();
    logic [63:0] rd;
    write_readback(CSR_A_PTR, 64'h1000);
    write_readback(CSR_B_PTR, 64'h2000);
    write_readback(CSR_LEN, 64'd8);
    write_readback(CSR_RES_PTR, 64'h3000);
    csr_write(3'd6, 64'h55);
    csr_read(3'd6, rd);
    check_value("unmapped index 6", rd, 64'd0);
    csr_read(3'd7, rd);
    check_value("unmapped index 7", rd, 64'd0);
  endtask

  // Programs one run, waits for idle and checks the memory traffic
  task automatic run_dot(input int len, input logic [ADDR_W-1:0] a_ptr,
                         input logic [ADDR_W-1:0] b_ptr, input logic [ADDR_W-1:0] res_ptr);
    logic [63:0]       expected;
    logic [63:0]       rd;
    logic [ADDR_W-1:0] addr;
    int                base;
    expected = '0;
    for (int i = 0; i < len; i++) begin
      expected = expected + mem_q[word_index(a_ptr + 32'(i * ELEM_BYTES))]
                          * mem_q[word_index(b_ptr + 32'(i * ELEM_BYTES))];
    end
    base = log_addr_q.size();
    csr_write(CSR_A_PTR, 64'(a_ptr));
    csr_write(CSR_B_PTR, 64'(b_ptr));
    csr_write(CSR_LEN, 64'(len));
    csr_write(CSR_RES_PTR, 64'(res_ptr));
    csr_write(CSR_START, 64'd1);
    rd = 64'd0;
    while (rd != 64'd1) begin
      csr_read(CSR_STATUS, rd);
    end
    check_value("request count", 64'(log_addr_q.size() - base), 64'(2 * len + 1));
    if (log_addr_q.size() == base + 2 * len + 1) begin
      for (int i = 0; i < 2 * len; i++) begin
        addr = (i < len) ? a_ptr + 32'(i * ELEM_BYTES)
                         : b_ptr + 32'((i - len) * ELEM_BYTES);
        check_value($sformatf("read %0d address", i), 64'(log_addr_q[base + i]), 64'(addr));
        check_value($sformatf("read %0d flag", i), 64'(log_we_q[base + i]), 64'd0);
      end
      check_value("result write flag", 64'(log_we_q[base + 2 * len]), 64'd1);
      check_value("result write address", 64'(log_addr_q[base + 2 * len]), 64'(res_ptr));
      check_value("result write data", log_data_q[base + 2 * len], expected);
    end
    check_value("result in memory", mem_q[word_index(res_ptr)], expected);
    csr_read(CSR_START, rd);
    check_value("start after done", rd, 64'd0);
  endtask

  task automatic test_back_pressure();
    logic                 r_we [3];
    logic [CSR_IDX_W-1:0] r_addr [3];
    logic [63:0]          r_data [3];
    send_cmd(1'b1, CSR_A_PTR, 64'h1200);
    send_cmd(1'b0, CSR_A_PTR, 64'd0);
    fork
      send_cmd(1'b0, CSR_LEN, 64'd0);
      begin
        repeat (6) begin
          @(negedge clk);
          check_value("command ready with FIFO full", 64'(cmd_ready), 64'd0);
          check_value("response held", 64'(resp_v), 64'd1);
        end
        for (int i = 0; i < 3; i++) begin
          recv_resp(r_we[i], r_addr[i], r_data[i]);
        end
      end
    join
    check_value("stalled response 0 flag", 64'(r_we[0]), 64'd1);
    check_value("stalled response 0 index", 64'(r_addr[0]), 64'(CSR_A_PTR));
    check_value("stalled response 0 data", r_data[0], 64'd0);
    check_value("stalled response 1 flag", 64'(r_we[1]), 64'd0);
    check_value("stalled response 1 index", 64'(r_addr[1]), 64'(CSR_A_PTR));
    check_value("stalled response 1 data", r_data[1], 64'h1200);
    check_value("stalled response 2 flag", 64'(r_we[2]), 64'd0);
    check_value("stalled response 2 index", 64'(r_addr[2]), 64'(CSR_LEN));
    check_value("stalled response 2 data", r_data[2], 64'd3);
  endtask

  initial begin
    n_checks   = 0;
    n_errors   = 0;
    reset      = 1'b1;
    cmd_v      = 1'b0;
    cmd_we     = 1'b0;
    cmd_addr   = '0;
    cmd_data   = '0;
    resp_ready = 1'b0;
    repeat (8) @(negedge clk);
    reset = 1'b0;

    test_reset_values();
    test_csr_round_trip();
    run_dot(8, 32'h1000, 32'h2000, 32'h3000);
    // Stale lanes 3 to 7 still hold data from the full run
    run_dot(3, 32'h1100, 32'h2100, 32'h3040);
    test_back_pressure();

    repeat (4) @(negedge clk);
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: tb/vdp_tb_sva.sv
`timescale 1ns/1ps

module vdp_tb_sva (
  input logic                          clk_i,
  input logic                          reset_i,
  input logic                          start_i,
  input logic                          mem_req_v_i,
  input logic                          mem_req_we_i,
  input logic [vdp_pkg::ADDR_W-1:0]    mem_req_addr_i,
  input logic [vdp_pkg::DATA_W-1:0]    mem_req_data_i,
  input logic                          mem_req_ready_i,
  input logic                          io_resp_v_i,
  input logic                          io_resp_we_i,
  input logic [vdp_pkg::CSR_IDX_W-1:0] io_resp_addr_i,
  input logic [vdp_pkg::DATA_W-1:0]    io_resp_data_i,
  input logic                          io_resp_ready_i
);

  // Stalled memory request holds
  mem_req_stable: assert property (
    @(posedge clk_i) disable iff (reset_i)
    mem_req_v_i && !mem_req_ready_i |=> mem_req_v_i && $stable(mem_req_we_i)
      && $stable(mem_req_addr_i) && $stable(mem_req_data_i)
  ) else $error("memory request changed while stalled");

  // Stalled host response holds
  resp_stable: assert property (
    @(posedge clk_i) disable iff (reset_i)
    io_resp_v_i && !io_resp_ready_i |=> io_resp_v_i && $stable(io_resp_we_i)
      && $stable(io_resp_addr_i) && $stable(io_resp_data_i)
  ) else $error("host response changed while stalled");

  // Memory stays quiet until the host starts a run
  idle_no_req: assert property (
    @(posedge clk_i) disable iff (reset_i)
    mem_req_v_i |-> start_i
  ) else $error("memory request issued while no run was started");

endmodule

// File: tb/vdp_clk_gen.sv
`timescale 1ns/1ps

module vdp_clk_gen #(
  parameter int PERIOD_NS = 4
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;
    end
  end

endmodule

// File: hdl/vdp_top.sv
`timescale 1ns/1ps

module vdp_top #(
  parameter int  VEC_LEN = vdp_pkg::VEC_LEN_MAX,
  localparam int FIFO_W  = 1 + vdp_pkg::CSR_IDX_W + vdp_pkg::DATA_W
) (
  input  logic                         clk_i,
  input  logic                         reset_i,

  input  logic                         io_cmd_v_i,
  input  logic                         io_cmd_we_i,
  input  logic [vdp_pkg::CSR_IDX_W-1:0] io_cmd_addr_i,
  input  logic [vdp_pkg::DATA_W-1:0]    io_cmd_data_i,
  output logic                         io_cmd_ready_o,

  output logic                         io_resp_v_o,
  output logic                         io_resp_we_o,
  output logic [vdp_pkg::CSR_IDX_W-1:0] io_resp_addr_o,
  output logic [vdp_pkg::DATA_W-1:0]    io_resp_data_o,
  input  logic                         io_resp_ready_i,

  output logic                         mem_req_v_o,
  output logic                         mem_req_we_o,
  output logic [vdp_pkg::ADDR_W-1:0]    mem_req_addr_o,
  output logic [vdp_pkg::DATA_W-1:0]    mem_req_data_o,
  input  logic                         mem_req_ready_i,
  input  logic                         mem_resp_v_i,
  input  logic [vdp_pkg::DATA_W-1:0]    mem_resp_data_i
);

  import vdp_pkg::*;

  logic [FIFO_W-1:0]    fifo_in;
  logic [FIFO_W-1:0]    fifo_out;
  logic                 head_v;
  logic                 head_we;
  logic [CSR_IDX_W-1:0] head_addr;
  logic [DATA_W-1:0]    head_data;
  logic                 head_yumi;
  logic                 start;
  logic [ADDR_W-1:0]    a_ptr;
  logic [ADDR_W-1:0]    b_ptr;
  logic [CNT_W-1:0]     len;
  logic [ADDR_W-1:0]    res_ptr;
  logic                 busy;
  logic                 done;
  logic                 clear;
  logic                 wr_v;
  logic                 wr_sel_b;
  logic [LANE_W-1:0]    wr_idx;
  logic [DATA_W-1:0]    wr_data;
  logic [DATA_W-1:0]    result;

  // Payload order is we, index, data
  assign fifo_in = {io_cmd_we_i, io_cmd_addr_i, io_cmd_data_i};
  assign {head_we, head_addr, head_data} = fifo_out;

  vdp_cmd_fifo #(.FIFO_W(FIFO_W)) u_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (io_cmd_v_i),
    .data_i  (fifo_in),
    .ready_o (io_cmd_ready_o),
    .v_o     (head_v),
    .data_o  (fifo_out),
    .yumi_i  (head_yumi)
  );

  vdp_csr_file u_csr (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cmd_v_i         (head_v),
    .cmd_we_i        (head_we),
    .cmd_addr_i      (head_addr),
    .cmd_data_i      (head_data),
    .cmd_yumi_o      (head_yumi),
    .io_resp_v_o     (io_resp_v_o),
    .io_resp_we_o    (io_resp_we_o),
    .io_resp_addr_o  (io_resp_addr_o),
    .io_resp_data_o  (io_resp_data_o),
    .io_resp_ready_i (io_resp_ready_i),
    .busy_i          (busy),
    .done_i          (done),
    .start_o         (start),
    .a_ptr_o         (a_ptr),
    .b_ptr_o         (b_ptr),
    .len_o           (len),
    .res_ptr_o       (res_ptr)
  );

  vdp_fetch_ctrl #(.VEC_LEN(VEC_LEN)) u_ctrl (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .start_i         (start),
    .a_ptr_i         (a_ptr),
    .b_ptr_i         (b_ptr),
    .len_i           (len),
    .res_ptr_i       (res_ptr),
    .busy_o          (busy),
    .done_o          (done),
    .mem_req_v_o     (mem_req_v_o),
    .mem_req_we_o    (mem_req_we_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_data_o  (mem_req_data_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_resp_v_i    (mem_resp_v_i),
    .mem_resp_data_i (mem_resp_data_i),
    .result_i        (result),
    .clear_o         (clear),
    .wr_v_o          (wr_v),
    .wr_sel_b_o      (wr_sel_b),
    .wr_idx_o        (wr_idx),
    .wr_data_o       (wr_data)
  );

  vdp_dot_unit #(.VEC_LEN(VEC_LEN)) u_dot (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .clear_i    (clear),
    .wr_v_i     (wr_v),
    .wr_sel_b_i (wr_sel_b),
    .wr_idx_i   (wr_idx),
    .wr_data_i  (wr_data),
    .result_o   (result)
  );

endmodule

// File: hdl/vdp_dot_unit.sv
`timescale 1ns/1ps

module vdp_dot_unit #(
  parameter int VEC_LEN = vdp_pkg::VEC_LEN_MAX
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      clear_i,
  input  logic                      wr_v_i,
  input  logic                      wr_sel_b_i,
  input  logic [vdp_pkg::LANE_W-1:0] wr_idx_i,
  input  logic [vdp_pkg::DATA_W-1:0] wr_data_i,
  output logic [vdp_pkg::DATA_W-1:0] result_o
);

  import vdp_pkg::*;

  logic [DATA_W-1:0] buf_a [VEC_LEN];
  logic [DATA_W-1:0] buf_b [VEC_LEN];

  // Heap ordered tree with the root at 0 and leaves from VEC_LEN-1 up
  logic [DATA_W-1:0] node [2*VEC_LEN-1];

  // Lanes a short run does not load must read as zero
  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      for (int i = 0; i < VEC_LEN; i++) begin
        buf_a[i] <= '0;
        buf_b[i] <= '0;
      end
    end else if (wr_v_i) begin
      if (wr_sel_b_i) begin
        buf_b[wr_idx_i] <= wr_data_i;
      end else begin
        buf_a[wr_idx_i] <= wr_data_i;
      end
    end
  end

  // Products truncated to DATA_W
  for (genvar i = 0; i < VEC_LEN; i++) begin : g_lane
    assign node[VEC_LEN-1+i] = buf_a[i] * buf_b[i];
  end

  for (genvar i = 0; i < VEC_LEN-1; i++) begin : g_tree
    assign node[i] = node[2*i+1] + node[2*i+2];
  end

  assign result_o = node[0];

endmodule

// File: hdl/vdp_fetch_ctrl.sv
`timescale 1ns/1ps

module vdp_fetch_ctrl #(
  parameter int VEC_LEN = vdp_pkg::VEC_LEN_MAX
) (
  input  logic                      clk_i,
  input  logic                      reset_i,

  // From the CSR file
  input  logic                      start_i,
  input  logic [vdp_pkg::ADDR_W-1:0] a_ptr_i,
  input  logic [vdp_pkg::ADDR_W-1:0] b_ptr_i,
  input  logic [vdp_pkg::CNT_W-1:0]  len_i,
  input  logic [vdp_pkg::ADDR_W-1:0] res_ptr_i,
  output logic                      busy_o,
  output logic                      done_o,

  // Memory port
  output logic                      mem_req_v_o,
  output logic                      mem_req_we_o,
  output logic [vdp_pkg::ADDR_W-1:0] mem_req_addr_o,
  output logic [vdp_pkg::DATA_W-1:0] mem_req_data_o,
  input  logic                      mem_req_ready_i,
  input  logic                      mem_resp_v_i,
  input  logic [vdp_pkg::DATA_W-1:0] mem_resp_data_i,

  // Dot unit
  input  logic [vdp_pkg::DATA_W-1:0] result_i,
  output logic                      clear_o,
  output logic                      wr_v_o,
  output logic                      wr_sel_b_o,
  output logic [vdp_pkg::LANE_W-1:0] wr_idx_o,
  output logic [vdp_pkg::DATA_W-1:0] wr_data_o
);

  import vdp_pkg::*;

  ctrl_state_e       state_r;
  ctrl_state_e       state_n;
  logic [CNT_W-1:0]  cnt_r;
  logic [CNT_W-1:0]  len_eff;
  logic              last_elem;
  logic [ADDR_W-1:0] elem_off;
  logic              req_fire;

  // Out of range lengths are clamped to 1..VEC_LEN
  assign len_eff = (len_i == '0) ? CNT_W'(1)
                 : (len_i > CNT_W'(VEC_LEN)) ? CNT_W'(VEC_LEN)
                 : len_i;

  assign last_elem = (cnt_r == len_eff - CNT_W'(1));
  assign elem_off  = ADDR_W'(cnt_r) * ADDR_W'(ELEM_BYTES);
  assign req_fire  = mem_req_v_o & mem_req_ready_i;

  always_comb begin
    state_n = state_r;
    case (state_r)
      S_IDLE:     if (start_i) state_n = S_ISSUE_A;
      S_ISSUE_A:  if (req_fire) state_n = S_WAIT_A;
      S_WAIT_A:   if (mem_resp_v_i) state_n = last_elem ? S_ISSUE_B : S_ISSUE_A;
      S_ISSUE_B:  if (req_fire) state_n = S_WAIT_B;
      S_WAIT_B:   if (mem_resp_v_i) state_n = last_elem ? S_ISSUE_WB : S_ISSUE_B;
      S_ISSUE_WB: if (req_fire) state_n = S_WAIT_WB;
      S_WAIT_WB:  if (mem_resp_v_i) state_n = S_IDLE;
      default:    state_n = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= S_IDLE;
      cnt_r   <= '0;
    end else begin
      state_r <= state_n;
      if (state_r == S_IDLE) begin
        cnt_r <= '0;
      end else if (wr_v_o) begin
        // Restart the count between vectors
        cnt_r <= last_elem ? '0 : cnt_r + CNT_W'(1);
      end
    end
  end

  always_comb begin
    case (state_r)
      S_ISSUE_B, S_WAIT_B:   mem_req_addr_o = b_ptr_i + elem_off;
      S_ISSUE_WB, S_WAIT_WB: mem_req_addr_o = res_ptr_i;
      default:               mem_req_addr_o = a_ptr_i + elem_off;
    endcase
  end

  assign mem_req_v_o    = (state_r == S_ISSUE_A) || (state_r == S_ISSUE_B)
                       || (state_r == S_ISSUE_WB);
  assign mem_req_we_o   = (state_r == S_ISSUE_WB);
  assign mem_req_data_o = mem_req_we_o ? result_i : '0;

  assign busy_o  = (state_r != S_IDLE);
  assign done_o  = (state_r == S_WAIT_WB) && mem_resp_v_i;
  assign clear_o = (state_r == S_IDLE) && start_i;

  // Each read beat goes straight into its lane
  assign wr_v_o     = mem_resp_v_i && ((state_r == S_WAIT_A) || (state_r == S_WAIT_B));
  assign wr_sel_b_o = (state_r == S_WAIT_B);
  assign wr_idx_o   = cnt_r[LANE_W-1:0];
  assign wr_data_o  = mem_resp_data_i;

endmodule

// File: hdl/vdp_csr_file.sv
`timescale 1ns/1ps

module vdp_csr_file (
  input  logic                         clk_i,
  input  logic                         reset_i,

  // Head of the command FIFO
  input  logic                         cmd_v_i,
  input  logic                         cmd_we_i,
  input  logic [vdp_pkg::CSR_IDX_W-1:0] cmd_addr_i,
  input  logic [vdp_pkg::DATA_W-1:0]    cmd_data_i,
  output logic                         cmd_yumi_o,

  // Host response
  output logic                         io_resp_v_o,
  output logic                         io_resp_we_o,
  output logic [vdp_pkg::CSR_IDX_W-1:0] io_resp_addr_o,
  output logic [vdp_pkg::DATA_W-1:0]    io_resp_data_o,
  input  logic                         io_resp_ready_i,

  // Controller side
  input  logic                         busy_i,
  input  logic                         done_i,
  output logic                         start_o,
  output logic [vdp_pkg::ADDR_W-1:0]    a_ptr_o,
  output logic [vdp_pkg::ADDR_W-1:0]    b_ptr_o,
  output logic [vdp_pkg::CNT_W-1:0]     len_o,
  output logic [vdp_pkg::ADDR_W-1:0]    res_ptr_o
);

  import vdp_pkg::*;

  csr_idx_e             idx;
  logic                 exec;
  logic                 resp_v_r;
  logic                 resp_we_r;
  logic [CSR_IDX_W-1:0] resp_addr_r;
  logic [DATA_W-1:0]    resp_data_r;
  logic [DATA_W-1:0]    rd_data;
  logic                 start_r;
  logic [ADDR_W-1:0]    a_ptr_r;
  logic [ADDR_W-1:0]    b_ptr_r;
  logic [CNT_W-1:0]     len_r;
  logic [ADDR_W-1:0]    res_ptr_r;

  assign idx  = csr_idx_e'(cmd_addr_i);
  // One command in flight; the next waits until the response is taken
  assign exec = cmd_v_i & ~resp_v_r;

  assign cmd_yumi_o = resp_v_r & io_resp_ready_i;

  always_comb begin
    case (idx)
      CSR_A_PTR:   rd_data = DATA_W'(a_ptr_r);
      CSR_B_PTR:   rd_data = DATA_W'(b_ptr_r);
      CSR_LEN:     rd_data = DATA_W'(len_r);
      CSR_START:   rd_data = DATA_W'(start_r);
      CSR_STATUS:  rd_data = DATA_W'(!busy_i);
      CSR_RES_PTR: rd_data = DATA_W'(res_ptr_r);
      default:     rd_data = '0;
    endcase
  end

  // Clear wins over set on the pending response flag
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_r <= 1'b0;
    end else if (cmd_yumi_o) begin
      resp_v_r <= 1'b0;
    end else if (exec) begin
      resp_v_r <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (exec) begin
      resp_we_r   <= cmd_we_i;
      resp_addr_r <= cmd_addr_i;
      resp_data_r <= cmd_we_i ? '0 : rd_data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      start_r   <= 1'b0;
      a_ptr_r   <= '0;
      b_ptr_r   <= '0;
      len_r     <= '0;
      res_ptr_r <= '0;
    end else begin
      if (done_i) begin
        start_r <= 1'b0;
      end
      if (exec && cmd_we_i) begin
        case (idx)
          CSR_A_PTR:   a_ptr_r   <= cmd_data_i[ADDR_W-1:0];
          CSR_B_PTR:   b_ptr_r   <= cmd_data_i[ADDR_W-1:0];
          CSR_LEN:     len_r     <= cmd_data_i[CNT_W-1:0];
          CSR_START:   start_r   <= cmd_data_i[0];
          CSR_RES_PTR: res_ptr_r <= cmd_data_i[ADDR_W-1:0];
          default: begin
          end
        endcase
      end
    end
  end

  assign io_resp_v_o    = resp_v_r;
  assign io_resp_we_o   = resp_we_r;
  assign io_resp_addr_o = resp_addr_r;
  assign io_resp_data_o = resp_data_r;

  assign start_o   = start_r;
  assign a_ptr_o   = a_ptr_r;
  assign b_ptr_o   = b_ptr_r;
  assign len_o     = len_r;
  assign res_ptr_o = res_ptr_r;

endmodule

// File: hdl/vdp_cmd_fifo.sv
`timescale 1ns/1ps

module vdp_cmd_fifo #(
  parameter int FIFO_W = 8
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              v_i,
  input  logic [FIFO_W-1:0] data_i,
  output logic              ready_o,
  output logic              v_o,
  output logic [FIFO_W-1:0] data_o,
  input  logic              yumi_i
);

  logic [FIFO_W-1:0] mem_q [2];
  logic              wptr_r;
  logic              rptr_r;
  logic [1:0]        count_r;
  logic              push;
  logic              pop;

  assign ready_o = (count_r != 2'd2);
  assign v_o     = (count_r != 2'd0);
  assign data_o  = mem_q[rptr_r];

  assign push = v_i & ready_o;
  assign pop  = yumi_i & v_o;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_r] <= data_i;
    end
  end

  // Pointers flip on every push or pop
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r  <= 1'b0;
      rptr_r  <= 1'b0;
      count_r <= 2'd0;
    end else begin
      if (push) begin
        wptr_r <= ~wptr_r;
      end
      if (pop) begin
        rptr_r <= ~rptr_r;
      end
      count_r <= count_r + 2'(push) - 2'(pop);
    end
  end

endmodule

// File: hdl/vdp_pkg.sv
package vdp_pkg;

  // Datapath and port widths
  parameter int DATA_W      = 64;
  parameter int ADDR_W      = 32;
  parameter int CSR_IDX_W   = 3;

  // Element layout in memory
  parameter int ELEM_BYTES  = 8;

  // Lane count of the dot unit
  parameter int VEC_LEN_MAX = 8;
  parameter int LANE_W      = $clog2(VEC_LEN_MAX);

  // Must hold VEC_LEN_MAX itself
  parameter int CNT_W       = $clog2(VEC_LEN_MAX) + 1;

  // Host visible register map with 6 and 7 unmapped
  typedef enum logic [CSR_IDX_W-1:0] {
    CSR_A_PTR   = 3'd0,
    CSR_B_PTR   = 3'd1,
    CSR_LEN     = 3'd2,
    CSR_START   = 3'd3,
    CSR_STATUS  = 3'd4,
    CSR_RES_PTR = 3'd5
  } csr_idx_e;

  // Controller states
  typedef enum logic [2:0] {
    S_IDLE     = 3'd0,
    S_ISSUE_A  = 3'd1,
    S_WAIT_A   = 3'd2,
    S_ISSUE_B  = 3'd3,
    S_WAIT_B   = 3'd4,
    S_ISSUE_WB = 3'd5,
    S_WAIT_WB  = 3'd6
  } ctrl_state_e;

endpackage
